// ==== bubsys_consts.svh ====
`ifndef BUBSYS_CONSTS_SVH
`define BUBSYS_CONSTS_SVH

////////////////////
// download indices
////////////////////

// rom image stream from the host loader
`define BUBSYS_IDX_ROM              16'd0

// dip switch and core config bytes, sent after the rom image
`define BUBSYS_IDX_DIPSW            16'd254

////////////////////
// rom image layout
////////////////////

// 0x00000 - 0x40fff   bubble memory user pages, sdram bank 0
// 0x41000 - 0x42fff   sound program, block ram
// 0x43000 - 0x431ff   bubble bootloader, block ram
// 0x43200 - 0x432ff   wavetable 1, block ram
// 0x43300 - 0x433ff   wavetable 2, block ram

// addr[19:12] above this page goes to block ram
`define BUBSYS_BRAM_REGION_PAGE     8'h40

// block ram addresses are rebased so the sound program starts at 0
`define BUBSYS_BRAM_BASE            14'h1000

////////////////////
// dip bank defaults
////////////////////

`define BUBSYS_DIPSW1_INIT          8'hFF
`define BUBSYS_DIPSW2_INIT          8'h42
`define BUBSYS_DIPSW3_INIT          8'hFF

// config bits 1:0 at zero means rotated screen
`define BUBSYS_CORECFG_INIT         8'h00

////////////////////
// bootloader prom
////////////////////

// word address width, one word per byte pair
`define BUBSYS_BOOTROM_AW           8
`define BUBSYS_BOOTROM_DEPTH        (1 << `BUBSYS_BOOTROM_AW)

`endif

// ==== bubsys_pkg.sv ====
`default_nettype none

package bubsys_pkg;

    // host download port
    typedef logic [15:0] ioctl_index_t;
    typedef logic [26:0] ioctl_addr_t;
    typedef logic [7:0]  byte_t;

    // misc joystick word, one bit per button
    typedef logic [15:0] joystick_t;

    // sdram programming write
    typedef logic [21:0] prog_sdram_addr_t;
    typedef logic [15:0] sdram_word_t;
    typedef logic [1:0]  sdram_mask_t;
    typedef logic [1:0]  sdram_bank_t;

    // block ram programming, byte addressed
    typedef logic [13:0] prom_addr_t;

    // one-hot: 0 sound rom, 1 bootloader, 2 wave1, 3 wave2
    typedef logic [3:0]  prom_cs_t;

    // bubble bootloader, word addressed
    typedef logic [7:0]  bootrom_addr_t;
    typedef logic [15:0] bootrom_word_t;

    // download router
    typedef enum logic [1:0] {
        LOADING,
        SDRAM_BUSY,
        DONE
    } router_state_t;

endpackage

`default_nettype wire

// ==== rom_download_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubsys_consts.svh"

module rom_download_router
    import bubsys_pkg::*;
(
    input  wire                 i_EMU_CLK72M,
    input  wire                 i_EMU_INITRST,

    input  wire ioctl_index_t   i_ioctl_index,
    input  wire ioctl_addr_t    i_ioctl_addr,
    input  wire byte_t          i_ioctl_data,
    input  wire                 i_ioctl_wr,
    output logic                o_ioctl_wait,

    output logic                o_rom_download_done,

    // sdram programming write, held until ack
    input  wire                 i_prog_sdram_ack,
    output logic                o_prog_sdram_en,
    output logic                o_prog_sdram_wr,
    output prog_sdram_addr_t    o_prog_sdram_addr,
    output sdram_word_t         o_prog_sdram_din,
    output sdram_mask_t         o_prog_sdram_mask,
    output sdram_bank_t         o_prog_sdram_ba,

    // block ram programming strobe
    output logic                o_prom_en,
    output logic                o_prom_wr,
    output prom_addr_t          o_prom_addr,
    output byte_t               o_prom_data,
    output prom_cs_t            o_prom_cs
);

    router_state_t  state;
    logic           rom_idx;
    logic           dip_idx;
    logic           bram_region;
    prom_cs_t       cs_next;

    assign rom_idx     = (i_ioctl_index == `BUBSYS_IDX_ROM);
    assign dip_idx     = (i_ioctl_index == `BUBSYS_IDX_DIPSW);
    assign bram_region = (i_ioctl_addr[19:12] > `BUBSYS_BRAM_REGION_PAGE);

    ////////////////////
    // chip select decode
    ////////////////////

    // sound program spans two 4k pages, the rest share one page
    always_comb begin
        if (i_ioctl_addr[13:12] == 2'd1 || i_ioctl_addr[13:12] == 2'd2) begin
            cs_next = 4'b0001;
        end else begin
            case (i_ioctl_addr[9:8])
                2'd0, 2'd1: cs_next = 4'b0010;
                2'd2:       cs_next = 4'b0100;
                default:    cs_next = 4'b1000;
            endcase
        end
    end

    ////////////////////
    // download fsm
    ////////////////////

    always_ff @(posedge i_EMU_CLK72M) begin
        if (i_EMU_INITRST || state == DONE) begin
            if (i_EMU_INITRST) begin
                state <= LOADING;
            end

            // everything parked at idle values
            o_prog_sdram_en   <= 1'b0;
            o_prog_sdram_addr <= 22'h3F_FFFF;
            o_prog_sdram_din  <= 16'hFFFF;
            o_prog_sdram_mask <= 2'b00;
            o_prog_sdram_ba   <= 2'd0;

            o_prom_en   <= 1'b0;
            o_prom_wr   <= 1'b0;
            o_prom_addr <= 14'h3FFF;
            o_prom_data <= 8'hFF;
            o_prom_cs   <= 4'b0000;
        end else begin
            o_prom_wr <= 1'b0;

            case (state)
                LOADING: begin
                    if (rom_idx && bram_region) begin
                        o_prog_sdram_en <= 1'b0;
                        o_prom_en       <= 1'b1;
                        if (i_ioctl_wr) begin
                            o_prom_wr   <= 1'b1;
                            o_prom_addr <= i_ioctl_addr[13:0] - `BUBSYS_BRAM_BASE;
                            o_prom_data <= i_ioctl_data;
                            o_prom_cs   <= cs_next;
                        end
                    end else if (rom_idx) begin
                        o_prog_sdram_en <= 1'b1;
                        o_prom_en       <= 1'b0;
                        if (i_ioctl_wr) begin
                            state             <= SDRAM_BUSY;
                            o_prog_sdram_addr <= {4'b0000, i_ioctl_addr[18:1]};
                            o_prog_sdram_din  <= {i_ioctl_data, i_ioctl_data};
                            // 68k big endian, odd byte is the low lane
                            o_prog_sdram_mask <= i_ioctl_addr[0] ? 2'b10 : 2'b01;
                            o_prog_sdram_ba   <= 2'd0;
                        end
                    end else if (dip_idx) begin
                        // dip bytes follow the rom image
                        state           <= DONE;
                        o_prog_sdram_en <= 1'b0;
                        o_prom_en       <= 1'b0;
                    end
                end

                SDRAM_BUSY: begin
                    // host is held off by o_ioctl_wait
                    if (i_prog_sdram_ack) begin
                        state <= LOADING;
                    end
                end

                default: begin
                    state <= DONE;
                end
            endcase
        end
    end

    assign o_prog_sdram_wr     = (state == SDRAM_BUSY);
    assign o_ioctl_wait        = (state == SDRAM_BUSY);
    assign o_rom_download_done = (state == DONE);

endmodule

`default_nettype wire

// ==== cabinet_io.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubsys_consts.svh"

module cabinet_io
    import bubsys_pkg::*;
(
    input  wire                 i_EMU_CLK72M,
    input  wire                 i_EMU_INITRST,

    input  wire                 i_rom_download_done,
    input  wire ioctl_index_t   i_ioctl_index,
    input  wire ioctl_addr_t    i_ioctl_addr,
    input  wire byte_t          i_ioctl_data,
    input  wire                 i_ioctl_wr,

    input  wire joystick_t      i_joystick0,
    input  wire joystick_t      i_joystick1,

    output byte_t               o_dipsw1,
    output byte_t               o_dipsw2,
    output byte_t               o_dipsw3,
    output byte_t               o_in0,
    output byte_t               o_in1,
    output byte_t               o_in2,
    output logic                o_video_rot
);

    byte_t  corecfg;
    logic   cfg_wr;

    ////////////////////
    // dip switch bank
    ////////////////////

    // writable during reset or once the rom image is in
    assign cfg_wr = i_ioctl_wr && (i_ioctl_index == `BUBSYS_IDX_DIPSW)
                    && (i_EMU_INITRST || i_rom_download_done);

    always_ff @(posedge i_EMU_CLK72M) begin
        if (i_EMU_INITRST) begin
            o_dipsw1 <= `BUBSYS_DIPSW1_INIT;
            o_dipsw2 <= `BUBSYS_DIPSW2_INIT;
            o_dipsw3 <= `BUBSYS_DIPSW3_INIT;
            corecfg  <= `BUBSYS_CORECFG_INIT;
        end

        // host write wins over the defaults
        if (cfg_wr) begin
            case (i_ioctl_addr[2:0])
                3'd0:    o_dipsw1 <= i_ioctl_data;
                3'd1:    o_dipsw2 <= i_ioctl_data;
                3'd2:    o_dipsw3 <= i_ioctl_data;
                3'd3:    corecfg  <= i_ioctl_data;
                default: ;
            endcase
        end
    end

    assign o_video_rot = (corecfg[1:0] == 2'd0);

    ////////////////////
    // input mapper
    ////////////////////

    // joystick bits: 0 right, 1 left, 2 down, 3 up, 4 service,
    // 5 coin, 6 start, 7..9 buttons 1..3

    // system: coins, service, starts
    assign o_in0 = {3'b111,
                    ~i_joystick1[6],
                    ~i_joystick0[6],
                    ~i_joystick0[4],
                    ~i_joystick1[5],
                    ~i_joystick0[5]};

    // player 1
    assign o_in1 = {1'b1,
                    ~i_joystick0[9], ~i_joystick0[8], ~i_joystick0[7],
                    ~i_joystick0[2], ~i_joystick0[3],
                    ~i_joystick0[0], ~i_joystick0[1]};

    // player 2, same layout
    assign o_in2 = {1'b1,
                    ~i_joystick1[9], ~i_joystick1[8], ~i_joystick1[7],
                    ~i_joystick1[2], ~i_joystick1[3],
                    ~i_joystick1[0], ~i_joystick1[1]};

endmodule

`default_nettype wire

// ==== bootrom_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubsys_consts.svh"

module bootrom_bram
    import bubsys_pkg::*;
(
    input  wire                 i_EMU_CLK72M,

    // programming side, byte stream
    input  wire prom_addr_t     i_prom_addr,
    input  wire byte_t          i_prom_data,
    input  wire                 i_prom_wr,
    input  wire                 i_prom_cs,

    // bubble controller read side
    input  wire bootrom_addr_t  i_bubrom_addr,
    input  wire                 i_bubrom_boot_cs,
    output bootrom_word_t       o_bubrom_boot_q
);

    bootrom_word_t  mem [`BUBSYS_BOOTROM_DEPTH];
    byte_t          data_hi;
    logic           wr_even;
    logic           wr_odd;

    assign wr_even = i_prom_wr && i_prom_cs && !i_prom_addr[0];
    assign wr_odd  = i_prom_wr && i_prom_cs && i_prom_addr[0];

    // even byte is the high half, kept until its partner arrives
    always_ff @(posedge i_EMU_CLK72M) begin
        if (wr_even) begin
            data_hi <= i_prom_data;
        end
    end

    // odd byte completes the word
    always_ff @(posedge i_EMU_CLK72M) begin
        if (wr_odd) begin
            mem[i_prom_addr[`BUBSYS_BOOTROM_AW:1]] <= {data_hi, i_prom_data};
        end
    end

    // registered read
    always_ff @(posedge i_EMU_CLK72M) begin
        if (i_bubrom_boot_cs) begin
            o_bubrom_boot_q <= mem[i_bubrom_addr];
        end
    end

endmodule

`default_nettype wire

// ==== bubsys_emu.sv ====
`timescale 1ns/1ps
`default_nettype none

module bubsys_emu
    import bubsys_pkg::*;
(
    input  wire                     i_EMU_CLK72M,
    input  wire                     i_EMU_INITRST,

    // host download port
    input  wire ioctl_index_t       i_ioctl_index,
    input  wire ioctl_addr_t        i_ioctl_addr,
    input  wire byte_t              i_ioctl_data,
    input  wire                     i_ioctl_wr,
    output wire                     o_ioctl_wait,
    output wire                     o_rom_download_done,

    // sdram programming write
    input  wire                     i_prog_sdram_ack,
    output wire                     o_prog_sdram_en,
    output wire                     o_prog_sdram_wr,
    output wire prog_sdram_addr_t   o_prog_sdram_addr,
    output wire sdram_word_t        o_prog_sdram_din,
    output wire sdram_mask_t        o_prog_sdram_mask,
    output wire sdram_bank_t        o_prog_sdram_ba,

    // block ram programming to the game board
    output wire                     o_prom_en,
    output wire                     o_prom_wr,
    output wire prom_addr_t         o_prom_addr,
    output wire byte_t              o_prom_data,
    output wire prom_cs_t           o_prom_cs,

    // bootloader read
    input  wire bootrom_addr_t      i_bubrom_addr,
    input  wire                     i_bubrom_boot_cs,
    output wire bootrom_word_t      o_bubrom_boot_q,

    // cabinet
    input  wire joystick_t          i_joystick0,
    input  wire joystick_t          i_joystick1,
    output wire byte_t              o_dipsw1,
    output wire byte_t              o_dipsw2,
    output wire byte_t              o_dipsw3,
    output wire byte_t              o_in0,
    output wire byte_t              o_in1,
    output wire byte_t              o_in2,
    output wire                     o_video_rot
);

    rom_download_router u_router (
        .i_EMU_CLK72M           (i_EMU_CLK72M),
        .i_EMU_INITRST          (i_EMU_INITRST),
        .i_ioctl_index          (i_ioctl_index),
        .i_ioctl_addr           (i_ioctl_addr),
        .i_ioctl_data           (i_ioctl_data),
        .i_ioctl_wr             (i_ioctl_wr),
        .o_ioctl_wait           (o_ioctl_wait),
        .o_rom_download_done    (o_rom_download_done),
        .i_prog_sdram_ack       (i_prog_sdram_ack),
        .o_prog_sdram_en        (o_prog_sdram_en),
        .o_prog_sdram_wr        (o_prog_sdram_wr),
        .o_prog_sdram_addr      (o_prog_sdram_addr),
        .o_prog_sdram_din       (o_prog_sdram_din),
        .o_prog_sdram_mask      (o_prog_sdram_mask),
        .o_prog_sdram_ba        (o_prog_sdram_ba),
        .o_prom_en              (o_prom_en),
        .o_prom_wr              (o_prom_wr),
        .o_prom_addr            (o_prom_addr),
        .o_prom_data            (o_prom_data),
        .o_prom_cs              (o_prom_cs)
    );

    cabinet_io u_cabinet (
        .i_EMU_CLK72M           (i_EMU_CLK72M),
        .i_EMU_INITRST          (i_EMU_INITRST),
        .i_rom_download_done    (o_rom_download_done),
        .i_ioctl_index          (i_ioctl_index),
        .i_ioctl_addr           (i_ioctl_addr),
        .i_ioctl_data           (i_ioctl_data),
        .i_ioctl_wr             (i_ioctl_wr),
        .i_joystick0            (i_joystick0),
        .i_joystick1            (i_joystick1),
        .o_dipsw1               (o_dipsw1),
        .o_dipsw2               (o_dipsw2),
        .o_dipsw3               (o_dipsw3),
        .o_in0                  (o_in0),
        .o_in1                  (o_in1),
        .o_in2                  (o_in2),
        .o_video_rot            (o_video_rot)
    );

    // bootloader sits on select bit 1
    bootrom_bram u_bootrom (
        .i_EMU_CLK72M           (i_EMU_CLK72M),
        .i_prom_addr            (o_prom_addr),
        .i_prom_data            (o_prom_data),
        .i_prom_wr              (o_prom_wr),
        .i_prom_cs              (o_prom_cs[1]),
        .i_bubrom_addr          (i_bubrom_addr),
        .i_bubrom_boot_cs       (i_bubrom_boot_cs),
        .o_bubrom_boot_q        (o_bubrom_boot_q)
    );

endmodule

`default_nettype wire

// ==== tb_bubsys_emu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bubsys_consts.svh"

module tb_bubsys_emu
    import bubsys_pkg::*;
();

    localparam int CLK_HALF = 10;

    logic               clk;
    logic               initrst;
    ioctl_index_t       ioctl_index;
    ioctl_addr_t        ioctl_addr;
    byte_t              ioctl_data;
    logic               ioctl_wr;
    logic               prog_sdram_ack;
    bootrom_addr_t      bubrom_addr;
    logic               bubrom_boot_cs;
    joystick_t          joy0;
    joystick_t          joy1;

    logic               ioctl_wait;
    logic               done;
    logic               sdram_en;
    logic               sdram_wr;
    prog_sdram_addr_t   sdram_addr;
    sdram_word_t        sdram_din;
    sdram_mask_t        sdram_mask;
    sdram_bank_t        sdram_ba;
    logic               prom_en;
    logic               prom_wr;
    prom_addr_t         prom_addr;
    byte_t              prom_data;
    prom_cs_t           prom_cs;
    bootrom_word_t      boot_q;
    byte_t              dipsw1;
    byte_t              dipsw2;
    byte_t              dipsw3;
    byte_t              in0;
    byte_t              in1;
    byte_t              in2;
    logic               video_rot;

    int                 checks;
    int                 errors;
    int                 tests;

    bubsys_emu dut (
        .i_EMU_CLK72M           (clk),
        .i_EMU_INITRST          (initrst),
        .i_ioctl_index          (ioctl_index),
        .i_ioctl_addr           (ioctl_addr),
        .i_ioctl_data           (ioctl_data),
        .i_ioctl_wr             (ioctl_wr),
        .o_ioctl_wait           (ioctl_wait),
        .o_rom_download_done    (done),
        .i_prog_sdram_ack       (prog_sdram_ack),
        .o_prog_sdram_en        (sdram_en),
        .o_prog_sdram_wr        (sdram_wr),
        .o_prog_sdram_addr      (sdram_addr),
        .o_prog_sdram_din       (sdram_din),
        .o_prog_sdram_mask      (sdram_mask),
        .o_prog_sdram_ba        (sdram_ba),
        .o_prom_en              (prom_en),
        .o_prom_wr              (prom_wr),
        .o_prom_addr            (prom_addr),
        .o_prom_data            (prom_data),
        .o_prom_cs              (prom_cs),
        .i_bubrom_addr          (bubrom_addr),
        .i_bubrom_boot_cs       (bubrom_boot_cs),
        .o_bubrom_boot_q        (boot_q),
        .i_joystick0            (joy0),
        .i_joystick1            (joy1),
        .o_dipsw1               (dipsw1),
        .o_dipsw2               (dipsw2),
        .o_dipsw3               (dipsw3),
        .o_in0                  (in0),
        .o_in1                  (in1),
        .o_in2                  (in2),
        .o_video_rot            (video_rot)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic tally_check(input string name, input logic bad,
                               input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (bad) begin
            errors++;
            $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic bit_eq(input string name, input logic got, input logic exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic byte_eq(input string name, input byte_t got, input byte_t exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic cs_eq(input string name, input prom_cs_t got, input prom_cs_t exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic prom_addr_eq(input string name, input prom_addr_t got,
                                input prom_addr_t exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic sdram_word_eq(input string name, input sdram_word_t got,
                                 input sdram_word_t exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic sdram_addr_eq(input string name, input prog_sdram_addr_t got,
                                 input prog_sdram_addr_t exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic mask_eq(input string name, input sdram_mask_t got, input sdram_mask_t exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic bank_eq(input string name, input sdram_bank_t got, input sdram_bank_t exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    task automatic boot_word_eq(input string name, input bootrom_word_t got,
                                input bootrom_word_t exp);
        tally_check(name, got !== exp, 32'(got), 32'(exp));
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////

    function automatic byte_t rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    // active low, left right up down then buttons 1..3
    function automatic byte_t player_byte(input joystick_t j);
        byte_t b;
        b[0] = ~j[1];
        b[1] = ~j[0];
        b[2] = ~j[3];
        b[3] = ~j[2];
        b[4] = ~j[7];
        b[5] = ~j[8];
        b[6] = ~j[9];
        b[7] = 1'b1;
        return b;
    endfunction

    function automatic byte_t system_byte(input joystick_t j0, input joystick_t j1);
        byte_t b;
        b = 8'hFF;
        b[0] = ~j0[5];
        b[1] = ~j1[5];
        b[2] = ~j0[4];
        b[3] = ~j0[6];
        b[4] = ~j1[6];
        return b;
    endfunction

    task automatic init_inputs();
        initrst        <= 1'b1;
        ioctl_index    <= `BUBSYS_IDX_ROM;
        ioctl_addr     <= '0;
        ioctl_data     <= '0;
        ioctl_wr       <= 1'b0;
        prog_sdram_ack <= 1'b0;
        bubrom_addr    <= '0;
        bubrom_boot_cs <= 1'b0;
        joy0           <= '0;
        joy1           <= '0;
    endtask

    task automatic drive_ack(input logic level);
        prog_sdram_ack <= level;
    endtask

    task automatic apply_reset();
        int i;
        @(posedge clk);
        initrst     <= 1'b1;
        ioctl_index <= `BUBSYS_IDX_ROM;
        ioctl_wr    <= 1'b0;
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        initrst <= 1'b0;
        @(negedge clk);
    endtask

    // one wr pulse, returns mid-cycle after the dut sampled it
    task automatic send_byte(input ioctl_index_t idx, input ioctl_addr_t addr,
                             input byte_t data);
        @(posedge clk);
        ioctl_index <= idx;
        ioctl_addr  <= addr;
        ioctl_data  <= data;
        ioctl_wr    <= 1'b1;
        @(posedge clk);
        ioctl_wr    <= 1'b0;
        @(negedge clk);
    endtask

    task automatic read_bootword(input bootrom_addr_t a, input bootrom_word_t exp);
        @(posedge clk);
        bubrom_addr    <= a;
        bubrom_boot_cs <= 1'b1;
        @(posedge clk);
        bubrom_boot_cs <= 1'b0;
        @(negedge clk);
        boot_word_eq("o_bubrom_boot_q", boot_q, exp);
    endtask

    // busy must hold until the cycle after the ack pulse
    task automatic await_release();
        logic ack_before;
        logic released;
        int   n;
        released = 1'b0;
        n = 0;
        while (!released && n < 16) begin
            ack_before = prog_sdram_ack;
            @(negedge clk);
            n++;
            if (ioctl_wait === 1'b0) begin
                released = 1'b1;
                if (ack_before !== 1'b1) begin
                    note_failure("o_ioctl_wait dropped without an ack on the cycle before");
                end
            end
        end
        if (!released) begin
            note_failure("timeout waiting for o_ioctl_wait to drop");
        end
        bit_eq("o_prog_sdram_wr", sdram_wr, 1'b0);
    endtask

    // sdram controller stand-in, acks 1 to 4 cycles late
    initial begin : sdram_ack_stub
        int delay;
        forever begin
            @(negedge clk);
            if (sdram_wr === 1'b1) begin
                delay = $urandom_range(1, 4);
                repeat (delay) @(posedge clk);
                drive_ack(1'b1);
                @(posedge clk);
                drive_ack(1'b0);
                @(negedge clk);
            end
        end
    end

    ////////////////////
    // directed tests
    ////////////////////

    task automatic reset_idle_values();
        byte_t d;
        d = rand_byte() & 8'h7F;
        bit_eq("o_prom_wr", prom_wr, 1'b0);
        bit_eq("o_prog_sdram_wr", sdram_wr, 1'b0);
        bit_eq("o_ioctl_wait", ioctl_wait, 1'b0);
        bit_eq("o_rom_download_done", done, 1'b0);
        byte_eq("o_dipsw1", dipsw1, `BUBSYS_DIPSW1_INIT);
        byte_eq("o_dipsw2", dipsw2, `BUBSYS_DIPSW2_INIT);
        byte_eq("o_dipsw3", dipsw3, `BUBSYS_DIPSW3_INIT);
        bit_eq("o_video_rot", video_rot, 1'b1);
        // still loading when sampled, so the bank ignores it
        send_byte(`BUBSYS_IDX_DIPSW, 27'h0, d);
        byte_eq("o_dipsw1", dipsw1, `BUBSYS_DIPSW1_INIT);
        bit_eq("o_rom_download_done", done, 1'b1);
        // bank open now, still before any rom data
        send_byte(`BUBSYS_IDX_DIPSW, 27'h0, d);
        byte_eq("o_dipsw1", dipsw1, d);
        // back to loading for the rom tests
        apply_reset();
        byte_eq("o_dipsw1", dipsw1, `BUBSYS_DIPSW1_INIT);
        bit_eq("o_rom_download_done", done, 1'b0);
    endtask

    task automatic bram_routing();
        ioctl_addr_t addrs [4];
        prom_cs_t    sels [4];
        prom_addr_t  offs [4];
        byte_t       d;
        int          i;
        addrs = '{27'h41000, 27'h43000, 27'h43200, 27'h43300};
        sels  = '{4'b0001, 4'b0010, 4'b0100, 4'b1000};
        offs  = '{14'h0000, 14'h2000, 14'h2200, 14'h2300};
        for (i = 0; i < 4; i++) begin
            d = rand_byte();
            send_byte(`BUBSYS_IDX_ROM, addrs[i], d);
            bit_eq("o_prom_wr", prom_wr, 1'b1);
            bit_eq("o_prom_en", prom_en, 1'b1);
            bit_eq("o_prog_sdram_en", sdram_en, 1'b0);
            bit_eq("o_ioctl_wait", ioctl_wait, 1'b0);
            prom_addr_eq("o_prom_addr", prom_addr, offs[i]);
            byte_eq("o_prom_data", prom_data, d);
            cs_eq("o_prom_cs", prom_cs, sels[i]);
            @(negedge clk);
            bit_eq("o_prom_wr", prom_wr, 1'b0);
        end
    endtask

    task automatic sdram_programming();
        ioctl_addr_t a [2];
        sdram_mask_t masks [2];
        byte_t       d;
        int          i;
        // even byte first, then its odd partner
        a     = '{27'h01234, 27'h01235};
        masks = '{2'b01, 2'b10};
        for (i = 0; i < 2; i++) begin
            d = rand_byte();
            send_byte(`BUBSYS_IDX_ROM, a[i], d);
            bit_eq("o_ioctl_wait", ioctl_wait, 1'b1);
            bit_eq("o_prog_sdram_wr", sdram_wr, 1'b1);
            bit_eq("o_prog_sdram_en", sdram_en, 1'b1);
            bit_eq("o_prom_en", prom_en, 1'b0);
            // both bytes share word 0x91a
            sdram_addr_eq("o_prog_sdram_addr", sdram_addr, 22'h0_091A);
            sdram_word_eq("o_prog_sdram_din", sdram_din, {d, d});
            mask_eq("o_prog_sdram_mask", sdram_mask, masks[i]);
            bank_eq("o_prog_sdram_ba", sdram_ba, 2'd0);
            await_release();
        end
    endtask

    task automatic bootloader_prom();
        ioctl_addr_t   base [3];
        bootrom_word_t words [3];
        int            i;
        base = '{27'h43000, 27'h43002, 27'h4310A};
        for (i = 0; i < 3; i++) begin
            words[i] = {rand_byte(), rand_byte()};
            send_byte(`BUBSYS_IDX_ROM, base[i], words[i][15:8]);
            send_byte(`BUBSYS_IDX_ROM, base[i] + 27'h1, words[i][7:0]);
        end
        for (i = 0; i < 3; i++) begin
            read_bootword(base[i][8:1], words[i]);
        end
    endtask

    task automatic done_and_dips();
        byte_t d [3];
        byte_t cfg;
        int    i;
        int    n;
        // the dip index alone ends the rom image
        @(posedge clk);
        ioctl_index <= `BUBSYS_IDX_DIPSW;
        n = 0;
        @(negedge clk);
        while (done !== 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            note_failure("timeout waiting for o_rom_download_done");
        end
        for (i = 0; i < 3; i++) begin
            d[i] = rand_byte();
            send_byte(`BUBSYS_IDX_DIPSW, ioctl_addr_t'(i), d[i]);
        end
        byte_eq("o_dipsw1", dipsw1, d[0]);
        byte_eq("o_dipsw2", dipsw2, d[1]);
        byte_eq("o_dipsw3", dipsw3, d[2]);
        cfg = rand_byte() | 8'h01;
        send_byte(`BUBSYS_IDX_DIPSW, 27'd3, cfg);
        bit_eq("o_video_rot", video_rot, 1'b0);
        cfg = rand_byte() & 8'hFC;
        send_byte(`BUBSYS_IDX_DIPSW, 27'd3, cfg);
        bit_eq("o_video_rot", video_rot, 1'b1);
        // rom bytes go nowhere once done
        send_byte(`BUBSYS_IDX_ROM, 27'h41000, rand_byte());
        bit_eq("o_prom_wr", prom_wr, 1'b0);
        bit_eq("o_prom_en", prom_en, 1'b0);
        prom_addr_eq("o_prom_addr", prom_addr, 14'h3FFF);
        send_byte(`BUBSYS_IDX_ROM, 27'h00010, rand_byte());
        bit_eq("o_prog_sdram_wr", sdram_wr, 1'b0);
        bit_eq("o_prog_sdram_en", sdram_en, 1'b0);
        sdram_addr_eq("o_prog_sdram_addr", sdram_addr, 22'h3F_FFFF);
        bit_eq("o_ioctl_wait", ioctl_wait, 1'b0);
        bit_eq("o_rom_download_done", done, 1'b1);
    endtask

    task automatic cabinet_inputs();
        int i;
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            joy0 <= joystick_t'($urandom());
            joy1 <= joystick_t'($urandom());
            @(negedge clk);
            byte_eq("o_in0", in0, system_byte(joy0, joy1));
            byte_eq("o_in1", in1, player_byte(joy0));
            byte_eq("o_in2", in2, player_byte(joy1));
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errs_before);
    endtask

    initial begin
        int errs_before;
        checks = 0;
        errors = 0;
        tests  = 0;
        void'($urandom(32'h9b94ec14));
        init_inputs();
        apply_reset();

        errs_before = errors;
        reset_idle_values();
        report_test("reset and idle values", errs_before);

        errs_before = errors;
        bram_routing();
        report_test("block ram routing", errs_before);

        errs_before = errors;
        sdram_programming();
        report_test("sdram programming", errs_before);

        errs_before = errors;
        bootloader_prom();
        report_test("bootloader prom", errs_before);

        errs_before = errors;
        done_and_dips();
        report_test("done and dip bank", errs_before);

        errs_before = errors;
        cabinet_inputs();
        report_test("cabinet inputs", errs_before);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
bubsys_pkg.sv
rom_download_router.sv
cabinet_io.sv
bootrom_bram.sv
bubsys_emu.sv
tb_bubsys_emu.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/1ps -f src.f \
    --top-module tb_bubsys_emu -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
